// ==== hdl/backend_pkg.sv ====
package backend_pkg;

   // datapath and register file sizing
   localparam int data_w    = 16;
   localparam int preg_w    = 6;
   localparam int num_preg  = 64;
   localparam int rob_idx_w = 6;

   // function-unit slots
   localparam int num_units = 3;
   localparam int slot_alu1 = 0;
   localparam int slot_alu2 = 1;
   localparam int slot_mult = 2;

   typedef enum logic [2:0] {
      alu_add    = 3'd0,
      alu_and    = 3'd1,
      alu_or     = 3'd2,
      alu_xor    = 3'd3,
      alu_sll    = 3'd4,
      alu_srl    = 3'd5,
      alu_slt    = 3'd6,
      alu_pass_b = 3'd7
   } alu_mode_e;

   // packet as it leaves the issue queue
   typedef struct packed {
      logic                 valid;
      logic [rob_idx_w-1:0] rob_idx;
      logic [preg_w-1:0]    dst_preg;
      logic [preg_w-1:0]    src1_preg;
      logic [preg_w-1:0]    src2_preg;
      logic [data_w-1:0]    imm;
      logic                 imm_vld;
      logic                 ldi;
      alu_mode_e            mode;
      logic                 inv_rt;
      logic                 reg_wrt;
   } inst_pkt_t;

   // packet after register read with its operands resolved
   typedef struct packed {
      logic                 valid;
      logic [rob_idx_w-1:0] rob_idx;
      logic [preg_w-1:0]    dst_preg;
      logic                 reg_wrt;
      logic [data_w-1:0]    op1;
      logic [data_w-1:0]    op2;
      logic [data_w-1:0]    imm;
      logic                 ldi;
      alu_mode_e            mode;
      logic                 inv_rt;
   } opnd_pkt_t;

   typedef struct packed {
      logic                 valid;
      logic [rob_idx_w-1:0] rob_idx;
      logic [preg_w-1:0]    dst_preg;
      logic                 reg_wrt;
      logic [data_w-1:0]    data;
   } result_t;

endpackage

// ==== hdl/phys_reg_file.sv ====
`timescale 1ns/1ns

module phys_reg_file (
   input  logic                                                    clk,
   input  logic                                                    rst_n,
   input  logic [2*backend_pkg::num_units-1:0][backend_pkg::preg_w-1:0] rd_addr,
   output logic [2*backend_pkg::num_units-1:0][backend_pkg::data_w-1:0] rd_data,
   input  logic [backend_pkg::num_units-1:0]                        wr_en,
   input  logic [backend_pkg::num_units-1:0][backend_pkg::preg_w-1:0]   wr_addr,
   input  logic [backend_pkg::num_units-1:0][backend_pkg::data_w-1:0]   wr_data
);

   import backend_pkg::*;

   localparam int num_rd = 2 * num_units;

   logic [data_w-1:0] regs [num_preg];

   // all registers read zero out of reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_preg; i++) begin
            regs[i] <= '0;
         end
      end else begin
         // later slots overwrite earlier ones on an address clash
         for (int w = 0; w < num_units; w++) begin
            if (wr_en[w]) begin
               regs[wr_addr[w]] <= wr_data[w];
            end
         end
      end
   end

   // combinational read with same-cycle write bypass
   always_comb begin
      for (int r = 0; r < num_rd; r++) begin
         rd_data[r] = regs[rd_addr[r]];
         // highest write slot wins
         for (int w = 0; w < num_units; w++) begin
            if (wr_en[w] && (wr_addr[w] == rd_addr[r])) begin
               rd_data[r] = wr_data[w];
            end
         end
      end
   end

endmodule

// ==== hdl/operand_stage.sv ====
`timescale 1ns/1ns

module operand_stage (
   input  logic                                                    clk,
   input  logic                                                    rst_n,
   input  logic                                                    stall,
   input  backend_pkg::inst_pkt_t [backend_pkg::num_units-1:0]     issue,
   output logic [2*backend_pkg::num_units-1:0][backend_pkg::preg_w-1:0] rd_addr,
   input  logic [2*backend_pkg::num_units-1:0][backend_pkg::data_w-1:0] rd_data,
   output backend_pkg::opnd_pkt_t [backend_pkg::num_units-1:0]     opnd
);

   import backend_pkg::*;

   inst_pkt_t [num_units-1:0] issue_q;
   opnd_pkt_t [num_units-1:0] opnd_d;
   opnd_pkt_t [num_units-1:0] opnd_q;

   // issue register drops packets offered during a stall
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < num_units; s++) begin
            issue_q[s].valid <= 1'b0;
         end
      end else if (!stall) begin
         issue_q <= issue;
      end
   end

   // port 2s reads src1 and port 2s+1 reads src2
   always_comb begin
      for (int s = 0; s < num_units; s++) begin
         rd_addr[2*s]   = issue_q[s].src1_preg;
         rd_addr[2*s+1] = issue_q[s].src2_preg;
      end
   end

   always_comb begin
      for (int s = 0; s < num_units; s++) begin
         opnd_d[s].valid    = issue_q[s].valid;
         opnd_d[s].rob_idx  = issue_q[s].rob_idx;
         opnd_d[s].dst_preg = issue_q[s].dst_preg;
         opnd_d[s].reg_wrt  = issue_q[s].reg_wrt;
         opnd_d[s].op1      = rd_data[2*s];
         // immediate replaces the second source
         opnd_d[s].op2      = issue_q[s].imm_vld ? issue_q[s].imm : rd_data[2*s+1];
         opnd_d[s].imm      = issue_q[s].imm;
         opnd_d[s].ldi      = issue_q[s].ldi;
         opnd_d[s].mode     = issue_q[s].mode;
         opnd_d[s].inv_rt   = issue_q[s].inv_rt;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < num_units; s++) begin
            opnd_q[s].valid <= 1'b0;
         end
      end else if (!stall) begin
         opnd_q <= opnd_d;
      end
   end

   assign opnd = opnd_q;

endmodule

// ==== hdl/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit (
   input  backend_pkg::opnd_pkt_t opnd,
   output backend_pkg::result_t   result
);

   import backend_pkg::*;

   logic [data_w-1:0] op2_eff;
   logic [data_w-1:0] sum;
   logic [3:0]        shamt;
   logic [data_w-1:0] alu_out;

   // inverted rt plus carry in turns add into subtract
   assign op2_eff = opnd.inv_rt ? ~opnd.op2 : opnd.op2;
   assign sum     = opnd.op1 + op2_eff + {{(data_w-1){1'b0}}, opnd.inv_rt};

   // shifts only look at the low nibble
   assign shamt = op2_eff[3:0];

   always_comb begin
      case (opnd.mode)
         alu_add: begin
            alu_out = sum;
         end
         alu_and: begin
            alu_out = opnd.op1 & op2_eff;
         end
         alu_or: begin
            alu_out = opnd.op1 | op2_eff;
         end
         alu_xor: begin
            alu_out = opnd.op1 ^ op2_eff;
         end
         alu_sll: begin
            alu_out = opnd.op1 << shamt;
         end
         alu_srl: begin
            alu_out = opnd.op1 >> shamt;
         end
         alu_slt: begin
            alu_out = {{(data_w-1){1'b0}}, ($signed(opnd.op1) < $signed(op2_eff))};
         end
         default: begin
            alu_out = op2_eff;
         end
      endcase
   end

   always_comb begin
      result.valid    = opnd.valid;
      result.rob_idx  = opnd.rob_idx;
      result.dst_preg = opnd.dst_preg;
      result.reg_wrt  = opnd.reg_wrt;
      // load immediate bypasses the ALU entirely
      result.data     = opnd.ldi ? opnd.imm : alu_out;
   end

endmodule

// ==== hdl/mult_unit.sv ====
`timescale 1ns/1ns

module mult_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  stall,
   input  backend_pkg::opnd_pkt_t opnd,
   output backend_pkg::result_t   result
);

   import backend_pkg::*;

   opnd_pkt_t         s1_q;
   result_t           s2_q;
   logic [data_w-1:0] prod_lo;

   // only the low half of the product is kept
   assign prod_lo = s1_q.op1 * s1_q.op2;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_q.valid <= 1'b0;
         s2_q.valid <= 1'b0;
      end else if (!stall) begin
         s1_q          <= opnd;
         s2_q.valid    <= s1_q.valid;
         s2_q.rob_idx  <= s1_q.rob_idx;
         s2_q.dst_preg <= s1_q.dst_preg;
         s2_q.reg_wrt  <= s1_q.reg_wrt;
         s2_q.data     <= prod_lo;
      end
   end

   assign result = s2_q;

endmodule

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/1ns

module writeback_stage (
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   input  logic                                                  stall,
   input  backend_pkg::result_t [backend_pkg::num_units-1:0]     ex_result,
   output logic [backend_pkg::num_units-1:0]                     wr_en,
   output logic [backend_pkg::num_units-1:0][backend_pkg::preg_w-1:0] wr_addr,
   output logic [backend_pkg::num_units-1:0][backend_pkg::data_w-1:0] wr_data,
   output backend_pkg::result_t [backend_pkg::num_units-1:0]     done
);

   import backend_pkg::*;

   result_t [slot_alu2:slot_alu1] alu_q;
   result_t [num_units-1:0]       wb_res;

   // ALU results get their writeback register here
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_q[slot_alu1].valid <= 1'b0;
         alu_q[slot_alu2].valid <= 1'b0;
      end else if (!stall) begin
         alu_q[slot_alu1] <= ex_result[slot_alu1];
         alu_q[slot_alu2] <= ex_result[slot_alu2];
      end
   end

   always_comb begin
      wb_res[slot_alu1] = alu_q[slot_alu1];
      wb_res[slot_alu2] = alu_q[slot_alu2];
      // multiplier output is already its stage-two register
      wb_res[slot_mult] = ex_result[slot_mult];
      for (int s = 0; s < num_units; s++) begin
         done[s]       = wb_res[s];
         // held results report once when the stall drops
         done[s].valid = wb_res[s].valid & ~stall;
         wr_en[s]      = done[s].valid & wb_res[s].reg_wrt;
         wr_addr[s]    = wb_res[s].dst_preg;
         wr_data[s]    = wb_res[s].data;
      end
   end

endmodule

// ==== hdl/exec_backend_top.sv ====
`timescale 1ns/1ns

module exec_backend_top (
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  logic                                           stall,
   input  backend_pkg::inst_pkt_t [backend_pkg::num_units-1:0] issue,
   output backend_pkg::result_t   [backend_pkg::num_units-1:0] done
);

   import backend_pkg::*;

   // register file read side has two ports per slot
   logic [2*num_units-1:0][preg_w-1:0] rd_addr;
   logic [2*num_units-1:0][data_w-1:0] rd_data;

   opnd_pkt_t [num_units-1:0] opnd;
   result_t   [num_units-1:0] ex_result;

   // write side from writeback
   logic [num_units-1:0]             wr_en;
   logic [num_units-1:0][preg_w-1:0] wr_addr;
   logic [num_units-1:0][data_w-1:0] wr_data;

   operand_stage operand_stage_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .stall   (stall),
      .issue   (issue),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .opnd    (opnd)
   );

   phys_reg_file phys_reg_file_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data)
   );

   alu_unit alu1_i (
      .opnd   (opnd[slot_alu1]),
      .result (ex_result[slot_alu1])
   );

   alu_unit alu2_i (
      .opnd   (opnd[slot_alu2]),
      .result (ex_result[slot_alu2])
   );

   mult_unit mult_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .stall  (stall),
      .opnd   (opnd[slot_mult]),
      .result (ex_result[slot_mult])
   );

   writeback_stage writeback_stage_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .stall     (stall),
      .ex_result (ex_result),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .done      (done)
   );

endmodule

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// report a mismatch and end the run
task automatic tb_fail(input string sig, input logic [31:0] got, input logic [31:0] exp);
   $display("[FAIL] %s got 0x%0h expected 0x%0h", sig, got, exp);
   $display("Simulation finished: FAIL");
   $fatal(1, "mismatch on %s", sig);
endtask

// compares index, destination, write flag and data of one completion
task automatic check_result(input string name,
                            input backend_pkg::result_t got,
                            input backend_pkg::result_t exp);
   if (got.rob_idx !== exp.rob_idx) begin
      tb_fail({name, ".rob_idx"}, 32'(got.rob_idx), 32'(exp.rob_idx));
   end
   if (got.dst_preg !== exp.dst_preg) begin
      tb_fail({name, ".dst_preg"}, 32'(got.dst_preg), 32'(exp.dst_preg));
   end
   if (got.reg_wrt !== exp.reg_wrt) begin
      tb_fail({name, ".reg_wrt"}, 32'(got.reg_wrt), 32'(exp.reg_wrt));
   end
   if (got.data !== exp.data) begin
      tb_fail({name, ".data"}, 32'(got.data), 32'(exp.data));
   end
endtask

// no slot may report completion
task automatic check_idle(input string name,
                          input backend_pkg::result_t [backend_pkg::num_units-1:0] done);
   for (int s = 0; s < backend_pkg::num_units; s++) begin
      if (done[s].valid !== 1'b0) begin
         tb_fail($sformatf("%s.done[%0d].valid", name, s), 32'(done[s].valid), 32'h0);
      end
   end
endtask

// a wait that ran out of cycles ends the run
task automatic report_timeout(input string what);
   $display("[FAIL] timed out after 200 cycles waiting for %s", what);
   $display("Simulation finished: FAIL");
   $fatal(1, "timeout");
endtask

`endif

// ==== bench/exec_backend_tb.sv ====
`timescale 1ns/1ns

module exec_backend_tb;

   import backend_pkg::*;

   `include "tb_checks.svh"

   logic clk;
   logic rst_n;
   logic stall;
   inst_pkt_t [num_units-1:0] issue;
   result_t   [num_units-1:0] done;

   int seed = 32'h74cbac27;

   // golden vectors with one entry per file line
   int        vec_phase[$];
   int        vec_slot[$];
   int        vec_gap[$];
   inst_pkt_t vec_pkt[$];
   result_t   vec_exp[$];

   result_t exp_q[num_units][$];
   result_t got_q[num_units][$];

   exec_backend_top exec_backend_top_i (
      .clk   (clk),
      .rst_n (rst_n),
      .stall (stall),
      .issue (issue),
      .done  (done)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // completion monitor samples done at each rising edge
   always @(posedge clk) begin
      if (rst_n) begin
         for (int s = 0; s < num_units; s++) begin
            if (done[s].valid) begin
               got_q[s].push_back(done[s]);
            end
         end
      end
   end

   // about one cycle in four
   function automatic logic pick_stall();
      return (($random(seed) & 3) == 0);
   endfunction

   task automatic load_golden();
      int          fd;
      int          cnt;
      string       line;
      int unsigned f [15];
      inst_pkt_t   pkt;
      result_t     res;
      fd = $fopen("bench/exec_backend_golden.txt", "r");
      if (fd == 0) begin
         $display("[FAIL] could not open bench/exec_backend_golden.txt");
         $display("Simulation finished: FAIL");
         $fatal(1, "missing golden file");
      end
      while (!$feof(fd)) begin
         line = "";
         cnt = $fgets(line, fd);
         if (line.len() < 2 || line.substr(0, 1) == "//") begin
            continue;
         end
         cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                       f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
         if (cnt != 15) begin
            $display("[FAIL] golden file line has %0d fields instead of 15: %s", cnt, line);
            $display("Simulation finished: FAIL");
            $fatal(1, "bad golden line");
         end
         pkt.valid     = f[2][0];
         pkt.rob_idx   = f[3][rob_idx_w-1:0];
         pkt.dst_preg  = f[4][preg_w-1:0];
         pkt.src1_preg = f[5][preg_w-1:0];
         pkt.src2_preg = f[6][preg_w-1:0];
         pkt.imm       = f[7][data_w-1:0];
         pkt.imm_vld   = f[8][0];
         pkt.ldi       = f[9][0];
         pkt.mode      = alu_mode_e'(f[10][2:0]);
         pkt.inv_rt    = f[11][0];
         pkt.reg_wrt   = f[12][0];
         res.valid     = 1'b1;
         res.rob_idx   = pkt.rob_idx;
         res.dst_preg  = pkt.dst_preg;
         res.reg_wrt   = pkt.reg_wrt;
         res.data      = f[14][data_w-1:0];
         vec_phase.push_back(f[0]);
         vec_slot.push_back(f[1]);
         vec_gap.push_back(f[13]);
         vec_pkt.push_back(pkt);
         vec_exp.push_back(res);
      end
      $fclose(fd);
   endtask

   task automatic drive_idle(input bit rand_stall);
      @(negedge clk);
      stall = rand_stall ? pick_stall() : 1'b0;
      issue = '0;
   endtask

   // issuer holds the bundle back while stall is high
   task automatic issue_bundle(input inst_pkt_t [num_units-1:0] bundle, input bit rand_stall);
      int cyc;
      bit sent;
      sent = 1'b0;
      cyc = 0;
      while (!sent && cyc < 200) begin
         @(negedge clk);
         cyc++;
         stall = rand_stall ? pick_stall() : 1'b0;
         if (stall) begin
            issue = '0;
         end else begin
            issue = bundle;
            sent = 1'b1;
         end
      end
      if (!sent) begin
         report_timeout("stall to drop before issue");
      end
   endtask

   task automatic drain_and_compare(input int phase);
      int cyc;
      bit all_in;
      @(negedge clk);
      stall = 1'b0;
      issue = '0;
      all_in = 1'b0;
      cyc = 0;
      while (!all_in && cyc < 200) begin
         @(negedge clk);
         cyc++;
         all_in = 1'b1;
         for (int s = 0; s < num_units; s++) begin
            if (got_q[s].size() < exp_q[s].size()) begin
               all_in = 1'b0;
            end
         end
      end
      if (!all_in) begin
         report_timeout($sformatf("phase %0d completions", phase));
      end
      // late duplicates would land in the queues here
      repeat (6) @(negedge clk);
      for (int s = 0; s < num_units; s++) begin
         if (got_q[s].size() != exp_q[s].size()) begin
            tb_fail($sformatf("done[%0d] count", s), got_q[s].size(), exp_q[s].size());
         end
         while (exp_q[s].size() > 0) begin
            check_result($sformatf("phase %0d done[%0d]", phase, s),
                         got_q[s].pop_front(), exp_q[s].pop_front());
         end
      end
   endtask

   initial begin
      int                        i;
      int                        phase;
      inst_pkt_t [num_units-1:0] bundle;
      rst_n = 1'b0;
      stall = 1'b0;
      issue = '0;
      load_golden();
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      // quiet pipeline after reset
      repeat (10) begin
         @(negedge clk);
         check_idle("exec_backend_top_i", done);
      end

      i = 0;
      while (i < vec_pkt.size()) begin
         phase = vec_phase[i];
         for (int g = 1; g < vec_gap[i]; g++) begin
            drive_idle(phase == 4);
         end
         bundle = '0;
         do begin
            bundle[vec_slot[i]] = vec_pkt[i];
            exp_q[vec_slot[i]].push_back(vec_exp[i]);
            i++;
         end while (i < vec_pkt.size() && vec_gap[i] == 0);
         issue_bundle(bundle, phase == 4);
         if (i == vec_pkt.size() || vec_phase[i] != phase) begin
            drain_and_compare(phase);
         end
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/backend_pkg.sv
hdl/phys_reg_file.sv
hdl/operand_stage.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/writeback_stage.sv
hdl/exec_backend_top.sv
bench/exec_backend_tb.sv

// ==== bench/exec_backend_golden.txt ====
// ph slot vld rob dst src1 src2 imm imm_vld ldi mode inv_rt reg_wrt gap exp_data (all hex)
// gap 0 issues with the line above, gap n leaves n-1 idle cycles before the issue
2 0 1 01 01 00 00 1234 0 1 0 0 1 1 1234
2 1 1 02 02 00 00 0f0f 0 1 0 0 1 0 0f0f
2 0 1 03 03 00 00 8001 0 1 0 0 1 1 8001
2 1 1 04 04 00 00 0005 0 1 0 0 1 0 0005
2 0 1 05 05 01 02 0000 0 0 0 0 1 4 2143
3 0 1 06 06 01 02 0000 0 0 1 0 1 4 0204
3 1 1 07 07 01 02 0000 0 0 2 0 1 0 1f3f
3 0 1 08 08 01 00 00ff 1 0 3 0 1 1 12cb
3 1 1 09 09 01 02 0000 0 0 0 1 1 0 0325
3 0 1 0a 0a 02 04 0000 0 0 4 0 1 1 e1e0
3 1 1 0b 0b 03 00 0004 1 0 5 0 1 0 0800
3 0 1 0c 0c 03 04 0000 0 0 6 0 1 1 0001
3 1 1 0d 0d 04 03 0000 0 0 6 0 1 0 0000
3 0 1 0e 0e 00 00 00a5 1 0 7 0 1 1 00a5
3 1 1 0f 0f 01 00 0001 1 0 0 1 1 0 1233
3 0 1 10 10 01 02 0000 0 0 1 1 1 1 1030
3 1 1 11 11 00 02 0000 0 0 7 1 1 0 f0f0
3 0 1 12 12 01 00 0014 1 0 4 0 1 1 2340
3 1 1 13 13 03 01 0000 0 0 6 1 1 0 0001
4 0 1 14 14 01 04 0000 0 0 0 0 1 4 1239
4 1 1 15 15 02 04 0000 0 0 3 0 1 0 0f0a
4 2 1 16 16 01 02 0000 0 0 0 0 1 0 1d0c
4 0 1 17 17 05 01 0000 0 0 0 1 1 1 0f0f
4 1 1 18 18 04 00 0003 1 0 4 0 1 0 0028
4 2 1 19 19 03 00 0003 1 0 0 0 1 0 8003
4 0 1 1a 1a 02 03 0000 0 0 2 0 1 1 8f0f
4 1 1 1b 1b 00 00 beef 0 1 0 0 1 0 beef
4 2 1 1c 1c 04 05 0000 0 0 0 0 1 0 a64f
4 0 1 1d 1d 01 00 0008 1 0 5 0 1 1 0012
4 1 1 1e 1e 05 00 00f0 1 0 1 0 1 0 0040
4 2 1 1f 1f 02 02 0000 0 0 0 0 1 0 c2e1
5 0 1 20 01 00 00 dead 0 1 0 0 0 4 dead
5 1 1 21 21 00 01 0000 0 0 0 0 1 4 1234
